// File: build.f
common/mem_port_pkg.sv
round_robin_arbiter/leading_one_trailing_one.sv
round_robin_arbiter/round_robin_arbiter.sv
src/access_ctrl.sv
src/client_mux.sv
src/shared_ram.sv
src/mem_port_top.sv
tests/mem_port_assertions.sv
tests/mem_port_tb.sv

// File: common/mem_port_pkg.sv
package mem_port_pkg;

    // ====================
    // Sizes
    // ====================

    // Clients sharing the RAM port
    localparam int NUM_CLIENTS = 4;

    // 64-word RAM
    localparam int ADDR_W = 6;

    // Word width for both write and read data
    localparam int DATA_W = 16;

    // ====================
    // Types
    // ====================

    // Controller sequence for one access
    // IDLE      arbitration open, waiting for any request
    // WAIT_GNT  arbiter is registering its pick
    // ACCESS    owner latched, RAM enabled for one edge
    // RELEASE   done pulse to the owner, read data valid
    typedef enum logic [1:0] {
        IDLE,
        WAIT_GNT,
        ACCESS,
        RELEASE
    } ctrl_state_e;

    // Access type, taken from the owner's write-enable
    typedef enum logic {
        OP_READ,
        OP_WRITE
    } mem_op_e;

endpackage : mem_port_pkg

// File: round_robin_arbiter/leading_one_trailing_one.sv
`timescale 1ns/1ps

module leading_one_trailing_one #(
    parameter int WIDTH = 4
) (
    input  logic [WIDTH-1:0]         data,
    output logic [$clog2(WIDTH)-1:0] leadingone,
    output logic [$clog2(WIDTH)-1:0] trailingone,
    output logic [WIDTH-1:0]         leadingone_vector,
    output logic [WIDTH-1:0]         trailingone_vector,
    output logic                     all_zeroes,
    output logic                     valid
);

    // ====================
    // Leading one
    // ====================

    // Upward scan, the highest set bit is written last
    always_comb
    begin
        leadingone        = '0;
        leadingone_vector = '0;
        for (int i = 0; i < WIDTH; i++)
        begin
            if (data[i])
            begin
                leadingone        = i[$clog2(WIDTH)-1:0];
                leadingone_vector = '0;
                leadingone_vector[i] = 1'b1;
            end
        end
    end

    // ====================
    // Trailing one
    // ====================

    // Downward scan, the lowest set bit is written last
    always_comb
    begin
        trailingone        = '0;
        trailingone_vector = '0;
        for (int i = WIDTH - 1; i >= 0; i--)
        begin
            if (data[i])
            begin
                trailingone        = i[$clog2(WIDTH)-1:0];
                trailingone_vector = '0;
                trailingone_vector[i] = 1'b1;
            end
        end
    end

    // Empty vector flags, indices read as zero then
    assign all_zeroes = ~|data;
    assign valid      = |data;

endmodule : leading_one_trailing_one

// File: round_robin_arbiter/round_robin_arbiter.sv
`timescale 1ns/1ps

module round_robin_arbiter #(
    parameter int CLIENTS = 4
) (
    input  logic               clk,
    input  logic               rst_n,
    input  logic [CLIENTS-1:0] req,
    output logic [CLIENTS-1:0] gnt
);

    // ====================
    // State and picks
    // ====================

    // Bits strictly below the last winner
    logic [CLIENTS-1:0] below_mask;
    // Every bit except the last winner
    logic [CLIENTS-1:0] excl_mask;

    logic [CLIENTS-1:0] req_below;
    logic [CLIENTS-1:0] req_wrap;
    logic               multi_req;

    logic [CLIENTS-1:0] below_pick;
    logic [CLIENTS-1:0] wrap_pick;
    logic               below_vld;
    logic               wrap_vld;

    logic [CLIENTS-1:0] win_vec;
    logic               win_vld;

    // More than one bit set when clearing the lowest one leaves something
    assign multi_req = |(req & (req - 1'b1));

    // Priority walks down from the last winner
    assign req_below = req & below_mask;

    // Wrap search starts again at the top, skipping the last winner
    // A lone requester keeps its bit so it is granted again
    assign req_wrap = multi_req ? (req & excl_mask) : req;

    // Highest set bit of the below-winner requests
    leading_one_trailing_one #(
        .WIDTH (CLIENTS)
    ) u_below_find (
        .data               (req_below),
        .leadingone         (),
        .trailingone        (),
        .leadingone_vector  (below_pick),
        .trailingone_vector (),
        .all_zeroes         (),
        .valid              (below_vld)
    );

    // Highest set bit of the wrapped requests
    leading_one_trailing_one #(
        .WIDTH (CLIENTS)
    ) u_wrap_find (
        .data               (req_wrap),
        .leadingone         (),
        .trailingone        (),
        .leadingone_vector  (wrap_pick),
        .trailingone_vector (),
        .all_zeroes         (),
        .valid              (wrap_vld)
    );

    // ====================
    // Winner select
    // ====================

    // Below-winner pick first, otherwise the wrapped pick
    always_comb
    begin
        if (below_vld)
        begin
            win_vec = below_pick;
        end
        else if (wrap_vld)
        begin
            win_vec = wrap_pick;
        end
        else
        begin
            win_vec = '0;
        end
    end

    assign win_vld = below_vld | wrap_vld;

    // Grant is a registered one-hot pulse
    // Masks only move on a real win so idle cycles keep the rotation
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            gnt        <= '0;
            below_mask <= '0;
            excl_mask  <= '1;
        end
        else
        begin
            gnt <= win_vec;
            if (win_vld)
            begin
                // One-hot minus one sets every bit under the winner
                below_mask <= win_vec - 1'b1;
                excl_mask  <= ~win_vec;
            end
        end
    end

endmodule : round_robin_arbiter

// File: run_sim.sh
#!/bin/sh
# Compile the testbench with Verilator and run it
# Success needs the pass line in the simulator output
cd "$(dirname "$0")" || exit 1

verilator --binary --assert -Wno-fatal --top-module mem_port_tb -f build.f -o mem_port_sim \
    && ./obj_dir/mem_port_sim 2>&1 | tee /dev/stderr | grep -x "Simulation PASSED" > /dev/null \
    && echo "run_sim: test run succeeded" \
    || { echo "run_sim: test run did not succeed"; exit 1; }

// File: src/access_ctrl.sv
`timescale 1ns/1ps

module access_ctrl (
    input  logic                               clk,
    input  logic                               rst_n,
    input  logic [mem_port_pkg::NUM_CLIENTS-1:0] req,
    input  logic [mem_port_pkg::NUM_CLIENTS-1:0] gnt,
    output logic [mem_port_pkg::NUM_CLIENTS-1:0] arb_req,
    output logic [mem_port_pkg::NUM_CLIENTS-1:0] owner,
    output logic [mem_port_pkg::NUM_CLIENTS-1:0] done,
    output logic                               ram_en
);

    mem_port_pkg::ctrl_state_e state;
    mem_port_pkg::ctrl_state_e state_nxt;

    // ====================
    // Next state
    // ====================

    always_comb
    begin
        state_nxt = state;
        case (state)
            mem_port_pkg::IDLE:
            begin
                // Arbiter sees the same requests this cycle
                if (|req)
                begin
                    state_nxt = mem_port_pkg::WAIT_GNT;
                end
            end
            mem_port_pkg::WAIT_GNT:
            begin
                // No grant means the request vanished, reopen arbitration
                if (|gnt)
                begin
                    state_nxt = mem_port_pkg::ACCESS;
                end
                else
                begin
                    state_nxt = mem_port_pkg::IDLE;
                end
            end
            mem_port_pkg::ACCESS:
            begin
                state_nxt = mem_port_pkg::RELEASE;
            end
            default:
            begin
                state_nxt = mem_port_pkg::IDLE;
            end
        endcase
    end

    // State and owner registers
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            state <= mem_port_pkg::IDLE;
            owner <= '0;
        end
        else
        begin
            state <= state_nxt;
            if (state == mem_port_pkg::WAIT_GNT)
            begin
                owner <= gnt;
            end
            else if (state == mem_port_pkg::RELEASE)
            begin
                owner <= '0;
            end
        end
    end

    // ====================
    // Outputs
    // ====================

    // Arbitration is open only while idle
    assign arb_req = (state == mem_port_pkg::IDLE) ? req : '0;

    // RAM is enabled for exactly one edge
    assign ram_en = (state == mem_port_pkg::ACCESS);

    // Done goes back to the owner alone
    assign done = (state == mem_port_pkg::RELEASE) ? owner : '0;

endmodule : access_ctrl

// File: src/client_mux.sv
`timescale 1ns/1ps

module client_mux (
    input  logic [mem_port_pkg::NUM_CLIENTS-1:0]                      owner,
    input  logic [mem_port_pkg::NUM_CLIENTS-1:0]                      client_we,
    input  logic [mem_port_pkg::NUM_CLIENTS*mem_port_pkg::ADDR_W-1:0] client_addr,
    input  logic [mem_port_pkg::NUM_CLIENTS*mem_port_pkg::DATA_W-1:0] client_wdata,
    output logic [mem_port_pkg::ADDR_W-1:0]                           sel_addr,
    output logic [mem_port_pkg::DATA_W-1:0]                           sel_wdata,
    output mem_port_pkg::mem_op_e                                     sel_op
);

    // Owner's write-enable, before conversion to an opcode
    logic sel_we;

    // ====================
    // AND-OR select
    // ====================

    // Owner is one-hot, so OR of the masked slices is that client's value
    // An empty owner yields zeros and a read
    always_comb
    begin
        sel_addr  = '0;
        sel_wdata = '0;
        sel_we    = 1'b0;
        for (int i = 0; i < mem_port_pkg::NUM_CLIENTS; i++)
        begin
            sel_addr = sel_addr
                | (client_addr[i*mem_port_pkg::ADDR_W +: mem_port_pkg::ADDR_W]
                   & {mem_port_pkg::ADDR_W{owner[i]}});
            sel_wdata = sel_wdata
                | (client_wdata[i*mem_port_pkg::DATA_W +: mem_port_pkg::DATA_W]
                   & {mem_port_pkg::DATA_W{owner[i]}});
            sel_we = sel_we | (client_we[i] & owner[i]);
        end
    end

    // Write-enable high means a write access
    assign sel_op = sel_we ? mem_port_pkg::OP_WRITE : mem_port_pkg::OP_READ;

endmodule : client_mux

// File: src/mem_port_top.sv
`timescale 1ns/1ps

module mem_port_top (
    input  logic                                                      clk,
    input  logic                                                      rst_n,
    input  logic [mem_port_pkg::NUM_CLIENTS-1:0]                      req,
    input  logic [mem_port_pkg::NUM_CLIENTS-1:0]                      client_we,
    input  logic [mem_port_pkg::NUM_CLIENTS*mem_port_pkg::ADDR_W-1:0] client_addr,
    input  logic [mem_port_pkg::NUM_CLIENTS*mem_port_pkg::DATA_W-1:0] client_wdata,
    output logic [mem_port_pkg::NUM_CLIENTS-1:0]                      done,
    output logic [mem_port_pkg::DATA_W-1:0]                           rdata
);

    // ====================
    // Control
    // ====================

    logic [mem_port_pkg::NUM_CLIENTS-1:0] arb_req;
    logic [mem_port_pkg::NUM_CLIENTS-1:0] gnt;
    logic [mem_port_pkg::NUM_CLIENTS-1:0] owner;
    logic                                 ram_en;

    // Datapath selected by the owner
    logic [mem_port_pkg::ADDR_W-1:0]      sel_addr;
    logic [mem_port_pkg::DATA_W-1:0]      sel_wdata;
    mem_port_pkg::mem_op_e                sel_op;

    access_ctrl u_access_ctrl (
        .clk     (clk),
        .rst_n   (rst_n),
        .req     (req),
        .gnt     (gnt),
        .arb_req (arb_req),
        .owner   (owner),
        .done    (done),
        .ram_en  (ram_en)
    );

    // Requests reach the arbiter only while the controller is idle
    round_robin_arbiter #(
        .CLIENTS (mem_port_pkg::NUM_CLIENTS)
    ) u_arbiter (
        .clk   (clk),
        .rst_n (rst_n),
        .req   (arb_req),
        .gnt   (gnt)
    );

    // ====================
    // Datapath
    // ====================

    client_mux u_client_mux (
        .owner        (owner),
        .client_we    (client_we),
        .client_addr  (client_addr),
        .client_wdata (client_wdata),
        .sel_addr     (sel_addr),
        .sel_wdata    (sel_wdata),
        .sel_op       (sel_op)
    );

    // Read data is broadcast, only the done client takes it
    shared_ram u_shared_ram (
        .clk    (clk),
        .en     (ram_en),
        .sel_op (sel_op),
        .addr   (sel_addr),
        .wdata  (sel_wdata),
        .rdata  (rdata)
    );

endmodule : mem_port_top

// File: src/shared_ram.sv
`timescale 1ns/1ps

module shared_ram (
    input  logic                            clk,
    input  logic                            en,
    input  mem_port_pkg::mem_op_e           sel_op,
    input  logic [mem_port_pkg::ADDR_W-1:0] addr,
    input  logic [mem_port_pkg::DATA_W-1:0] wdata,
    output logic [mem_port_pkg::DATA_W-1:0] rdata
);

    // ====================
    // Storage
    // ====================

    // One word per address
    logic [mem_port_pkg::DATA_W-1:0] mem [2**mem_port_pkg::ADDR_W];

    // Single port, one access per enabled edge
    // Read data holds its value across writes and idle cycles
    always_ff @(posedge clk)
    begin
        if (en)
        begin
            if (sel_op == mem_port_pkg::OP_WRITE)
            begin
                mem[addr] <= wdata;
            end
            else
            begin
                // Registered read, valid the cycle after the enable
                rdata <= mem[addr];
            end
        end
    end

endmodule : shared_ram

// File: tests/mem_port_assertions.sv
`timescale 1ns/1ps

module mem_port_assertions (
    input logic                                 clk,
    input logic                                 rst_n,
    input logic [mem_port_pkg::NUM_CLIENTS-1:0] arb_req,
    input logic [mem_port_pkg::NUM_CLIENTS-1:0] gnt,
    input logic [mem_port_pkg::NUM_CLIENTS-1:0] done
);

    // Count of failed assertions
    int fail_count = 0;

    // ====================
    // One-hot checks
    // ====================

    gnt_onehot: assert property (@(posedge clk) disable iff (!rst_n) $onehot0(gnt))
    else
    begin
        $error("gnt has more than one bit set: %b", gnt);
        fail_count++;
    end

    done_onehot: assert property (@(posedge clk) disable iff (!rst_n) $onehot0(done))
    else
    begin
        $error("done has more than one bit set: %b", done);
        fail_count++;
    end

    // ====================
    // Sequencing
    // ====================

    // Grant only for a client that was requesting while idle
    gnt_from_idle: assert property (@(posedge clk) disable iff (!rst_n)
        (gnt & ~$past(arb_req)) == '0)
    else
    begin
        $error("gnt %b without an idle request", gnt);
        fail_count++;
    end

    // Done lands on the granted client three edges after the request edge
    done_after_gnt: assert property (@(posedge clk) disable iff (!rst_n)
        done == $past(gnt, 2))
    else
    begin
        $error("done %b does not match the grant two cycles earlier", done);
        fail_count++;
    end

endmodule : mem_port_assertions

// Attach the checks to every instance of the top level
bind mem_port_top mem_port_assertions u_assertions (
    .clk     (clk),
    .rst_n   (rst_n),
    .arb_req (arb_req),
    .gnt     (gnt),
    .done    (done)
);

// File: tests/mem_port_tb.sv
`timescale 1ns/1ps

module mem_port_tb;

    // ====================
    // Testbench constants
    // ====================

    localparam int CLK_PERIOD   = 8;
    localparam int RESET_CYCLES = 10;
    localparam int NUM_STEPS    = 14;
    // Quiet cycles checked by an idle step
    localparam int IDLE_CYCLES  = 5;
    // Longest wait for one done pulse before giving up
    localparam int DONE_LIMIT   = 8;
    localparam int WATCHDOG_NS  = (NUM_STEPS * 10 + RESET_CYCLES) * CLK_PERIOD;

    logic                                                      clk;
    logic                                                      rst_n;
    logic [mem_port_pkg::NUM_CLIENTS-1:0]                      req;
    logic [mem_port_pkg::NUM_CLIENTS-1:0]                      client_we;
    logic [mem_port_pkg::NUM_CLIENTS*mem_port_pkg::ADDR_W-1:0] client_addr;
    logic [mem_port_pkg::NUM_CLIENTS*mem_port_pkg::DATA_W-1:0] client_wdata;
    logic [mem_port_pkg::NUM_CLIENTS-1:0]                      done;
    logic [mem_port_pkg::DATA_W-1:0]                           rdata;

    // Stimulus table, one row per step, mask of zero means an idle step
    logic [mem_port_pkg::NUM_CLIENTS-1:0] tbl_mask  [NUM_STEPS];
    logic [mem_port_pkg::NUM_CLIENTS-1:0] tbl_we    [NUM_STEPS];
    logic [mem_port_pkg::ADDR_W-1:0]      tbl_addr  [NUM_STEPS][mem_port_pkg::NUM_CLIENTS];
    logic [mem_port_pkg::DATA_W-1:0]      tbl_wdata [NUM_STEPS][mem_port_pkg::NUM_CLIENTS];
    // Write data replaced by random words
    logic                                 tbl_rnd   [NUM_STEPS];

    // Reference model state
    logic [mem_port_pkg::DATA_W-1:0] shadow [2**mem_port_pkg::ADDR_W];
    int                              last_winner;
    integer                          seed;

    mem_port_top mem_port_top_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .req          (req),
        .client_we    (client_we),
        .client_addr  (client_addr),
        .client_wdata (client_wdata),
        .done         (done),
        .rdata        (rdata)
    );

    initial
    begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // ====================
    // Helpers
    // ====================

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("Simulation FAILED");
        $fatal(1, "Run stopped");
    endtask

    task automatic set_step(input int idx, input logic [3:0] mask, input logic [3:0] we,
                            input int a0, input int a1, input int a2, input int a3,
                            input logic [15:0] d0, input logic [15:0] d1,
                            input logic [15:0] d2, input logic [15:0] d3, input logic rnd);
        tbl_mask[idx]     = mask;
        tbl_we[idx]       = we;
        tbl_addr[idx][0]  = 6'(a0);
        tbl_addr[idx][1]  = 6'(a1);
        tbl_addr[idx][2]  = 6'(a2);
        tbl_addr[idx][3]  = 6'(a3);
        tbl_wdata[idx][0] = d0;
        tbl_wdata[idx][1] = d1;
        tbl_wdata[idx][2] = d2;
        tbl_wdata[idx][3] = d3;
        tbl_rnd[idx]      = rnd;
    endtask

    // Round-robin rule, downward from the last winner with wrap to the top
    function automatic int predict_winner(input logic [3:0] pending, input int last);
        int pick;
        int count;
        pick  = -1;
        count = 0;
        for (int i = 0; i < mem_port_pkg::NUM_CLIENTS; i++)
        begin
            count += pending[i];
        end
        for (int i = mem_port_pkg::NUM_CLIENTS - 1; i >= 0; i--)
        begin
            if (pick < 0 && pending[i] && i < last)
            begin
                pick = i;
            end
        end
        // Last winner skipped unless it is the lone requester
        for (int i = mem_port_pkg::NUM_CLIENTS - 1; i >= 0; i--)
        begin
            if (pick < 0 && pending[i] && (i != last || count == 1))
            begin
                pick = i;
            end
        end
        return pick;
    endfunction

    task automatic check_idle(input int cycles);
        for (int n = 0; n < cycles; n++)
        begin
            @(posedge clk);
            #1;
            assert (done == '0)
            else fail_run($sformatf("Error at %0t: done is %b, expected 0000", $time, done));
        end
    endtask

    // Drive one table row, then follow each done pulse against the model
    task automatic apply_step(input int s);
        logic [3:0]  pending;
        logic [3:0]  expected;
        logic [15:0] data [mem_port_pkg::NUM_CLIENTS];
        int          winner;
        int          cycles;
        int          latency;
        @(posedge clk);
        #1;
        if (tbl_mask[s] == '0)
        begin
            check_idle(IDLE_CYCLES);
            return;
        end
        for (int c = 0; c < mem_port_pkg::NUM_CLIENTS; c++)
        begin
            data[c] = tbl_rnd[s] ? 16'($random(seed)) : tbl_wdata[s][c];
            client_addr[c*mem_port_pkg::ADDR_W +: mem_port_pkg::ADDR_W] = tbl_addr[s][c];
            client_wdata[c*mem_port_pkg::DATA_W +: mem_port_pkg::DATA_W] = data[c];
        end
        client_we = tbl_we[s];
        req       = tbl_mask[s];
        pending   = tbl_mask[s];
        // Three edges from an idle start, one more after a previous done
        latency   = 3;
        while (pending != '0)
        begin
            winner           = predict_winner(pending, last_winner);
            expected         = '0;
            expected[winner] = 1'b1;
            cycles           = 0;
            do
            begin
                @(posedge clk);
                #1;
                cycles++;
            end
            while (done == '0 && cycles < DONE_LIMIT);
            assert (done != '0)
            else fail_run($sformatf("No done pulse within %0d cycles in step %0d", cycles, s));
            assert (done == expected)
            else fail_run($sformatf("Error at %0t: done is %b, expected %b",
                                    $time, done, expected));
            assert (cycles == latency)
            else fail_run($sformatf("Error at %0t: done latency is %0d, expected %0d",
                                    $time, cycles, latency));
            if (tbl_we[s][winner])
            begin
                shadow[tbl_addr[s][winner]] = data[winner];
            end
            else
            begin
                assert (rdata == shadow[tbl_addr[s][winner]])
                else fail_run($sformatf("Error at %0t: rdata is %h, expected %h",
                                        $time, rdata, shadow[tbl_addr[s][winner]]));
            end
            // Served client drops its request
            req[winner]     = 1'b0;
            pending[winner] = 1'b0;
            last_winner     = winner;
            latency         = 4;
        end
    endtask

    // ====================
    // Main sequence
    // ====================

    initial
    begin
        rst_n        = 1'b0;
        req          = '0;
        client_we    = '0;
        client_addr  = '0;
        client_wdata = '0;
        seed         = 32'hd76533b2;
        last_winner  = -1;

        // Idle, single client, contention, lone client, mixed reads
        set_step(0,  4'b0000, 4'b0000, 0,  0,  0,  0,  16'h0, 16'h0, 16'h0, 16'h0, 1'b0);
        set_step(1,  4'b0010, 4'b0010, 0,  5,  0,  0,  16'h0, 16'h1234, 16'h0, 16'h0, 1'b0);
        set_step(2,  4'b0010, 4'b0000, 0,  5,  0,  0,  16'h0, 16'h0, 16'h0, 16'h0, 1'b0);
        set_step(3,  4'b1111, 4'b1111, 10, 11, 12, 13, 16'h0, 16'h0, 16'h0, 16'h0, 1'b1);
        set_step(4,  4'b1111, 4'b0000, 13, 12, 11, 10, 16'h0, 16'h0, 16'h0, 16'h0, 1'b0);
        set_step(5,  4'b1011, 4'b1011, 50, 51, 0,  53, 16'ha5a5, 16'h5a5a, 16'h0, 16'hc3c3, 1'b0);
        set_step(6,  4'b0100, 4'b0000, 0,  0,  12, 0,  16'h0, 16'h0, 16'h0, 16'h0, 1'b0);
        set_step(7,  4'b0100, 4'b0100, 0,  0,  20, 0,  16'h0, 16'h0, 16'h0, 16'h0, 1'b1);
        set_step(8,  4'b0100, 4'b0000, 0,  0,  20, 0,  16'h0, 16'h0, 16'h0, 16'h0, 1'b0);
        set_step(9,  4'b1111, 4'b0111, 30, 30, 31, 10, 16'h0, 16'h0, 16'h0, 16'h0, 1'b1);
        set_step(10, 4'b1111, 4'b0000, 30, 31, 11, 50, 16'h0, 16'h0, 16'h0, 16'h0, 1'b0);
        set_step(11, 4'b0101, 4'b0101, 40, 0,  41, 0,  16'h0f0f, 16'h0, 16'hf0f0, 16'h0, 1'b0);
        set_step(12, 4'b0110, 4'b0000, 0,  40, 41, 0,  16'h0, 16'h0, 16'h0, 16'h0, 1'b0);
        set_step(13, 4'b0000, 4'b0000, 0,  0,  0,  0,  16'h0, 16'h0, 16'h0, 16'h0, 1'b0);

        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst_n = 1'b1;
        assert (done == '0)
        else fail_run($sformatf("Error at %0t: done is %b after reset, expected 0000",
                                $time, done));

        for (int s = 0; s < NUM_STEPS; s++)
        begin
            apply_step(s);
        end

        if (mem_port_top_i.u_assertions.fail_count == 0)
        begin
            $display("Simulation PASSED");
            $finish;
        end
        else
        begin
            fail_run($sformatf("Bound assertions failed %0d times",
                               mem_port_top_i.u_assertions.fail_count));
        end
    end

    // Watchdog sized from the table length and the reset time
    initial
    begin
        #(WATCHDOG_NS);
        fail_run($sformatf("Timeout, the run did not finish within %0d ns", WATCHDOG_NS));
    end

endmodule : mem_port_tb
